// ==== logic/dcache_pkg.sv ====
package dcache_pkg;

    // bus word
    localparam int data_width = 32;
    localparam int data_bytes = 4;
    localparam int align_bits = 2;

    // cache geometry
    localparam int offset_bits = 2;
    localparam int num_words = 2 ** offset_bits;
    localparam int index_bits = 2;
    localparam int num_sets = 2 ** index_bits;
    localparam int way_bits = 2;
    localparam int num_ways = 2 ** way_bits;
    localparam int tag_bits = data_width - offset_bits - index_bits - align_bits;

    // line storage address is way, index, offset
    localparam int bram_addr_bits = way_bits + index_bits + offset_bits;

    // backing memory depth in words
    localparam int mem_words_bits = 8;

    typedef logic [data_width-1:0] word_t;
    typedef logic [data_bytes-1:0] byte_en_t;
    typedef logic [data_width-1:0] addr_t;

    typedef logic [tag_bits-1:0] tag_t;
    typedef logic [index_bits-1:0] index_t;
    typedef logic [offset_bits-1:0] offset_t;
    typedef logic [way_bits-1:0] way_t;

    // one bit per inner node of the replacement tree
    typedef logic [num_ways-2:0] select_t;

    typedef enum logic [1:0] {
        miss_idle,
        miss_refill,
        miss_writeback
    } miss_state_t;

endpackage

// ==== logic/cbus_if.sv ====
`timescale 1ns/1ps

interface cbus_if;
    import dcache_pkg::*;

    // request side, held for a whole burst
    logic valid;
    logic is_write;
    addr_t addr;
    word_t wdata;

    // one word per okay, last on the fourth
    logic okay;
    logic last;
    word_t rdata;

    modport master (
        output valid, is_write, addr, wdata,
        input okay, last, rdata
    );

    modport slave (
        input valid, is_write, addr, wdata,
        output okay, last, rdata
    );

endinterface

// ==== logic/dual_port_bram.sv ====
`timescale 1ns/1ps

module dual_port_bram #(
    parameter int data_width = 32,
    parameter int addr_width = 6
) (
    input  logic clk,

    input  logic [data_width/8-1:0] we_a,
    input  logic [addr_width-1:0] addr_a,
    input  logic [data_width-1:0] din_a,
    output logic [data_width-1:0] dout_a,

    input  logic [data_width/8-1:0] we_b,
    input  logic [addr_width-1:0] addr_b,
    input  logic [data_width-1:0] din_b,
    output logic [data_width-1:0] dout_b
);

    logic [data_width-1:0] ram [2 ** addr_width];

    // read-first on both ports, the old word shows up on dout
    always_ff @(posedge clk) begin
        dout_a <= ram[addr_a];
        dout_b <= ram[addr_b];
        for (int i = 0; i < data_width / 8; i++) begin
            if (we_a[i]) begin
                ram[addr_a][i*8 +: 8] <= din_a[i*8 +: 8];
            end
            if (we_b[i]) begin
                ram[addr_b][i*8 +: 8] <= din_b[i*8 +: 8];
            end
        end
    end

endmodule

// ==== logic/plru_tree.sv ====
`timescale 1ns/1ps

module plru_tree (
    input  dcache_pkg::select_t select,
    input  dcache_pkg::way_t hit_way,
    output dcache_pkg::way_t victim_way,
    output dcache_pkg::select_t new_select
);
    import dcache_pkg::*;

    select_t next_bits;

    // bit 0 is the root: 0 means the lower half (ways 0 and 1) is older
    // bit 1 orders ways 0/1, bit 2 orders ways 2/3
    always_comb begin
        victim_way[1] = select[0];
        if (select[0]) begin
            victim_way[0] = select[2];
        end else begin
            victim_way[0] = select[1];
        end
    end

    // turn the bits on the accessed path away from that way
    always_comb begin
        next_bits = select;
        next_bits[0] = ~hit_way[1];
        if (hit_way[1]) begin
            next_bits[2] = ~hit_way[0];
        end else begin
            next_bits[1] = ~hit_way[0];
        end
    end

    // the other subtree keeps its ordering
    assign new_select = next_bits;

endmodule

// ==== logic/dcache.sv ====
`timescale 1ns/1ps

module dcache (
    input  logic clk,
    input  logic resetn,

    input  logic req_valid,
    input  dcache_pkg::addr_t req_addr,
    input  logic req_is_write,
    input  dcache_pkg::byte_en_t req_byte_en,
    input  dcache_pkg::word_t req_wdata,
    output logic addr_ok,
    output logic data_ok,
    output dcache_pkg::word_t rdata,

    cbus_if.master mem
);
    import dcache_pkg::*;

    // per-set line state and tree bits
    logic [num_ways-1:0] valid_bits [num_sets];
    logic [num_ways-1:0] dirty_bits [num_sets];
    tag_t tags [num_sets][num_ways];
    select_t tree_bits [num_sets];

    tag_t req_tag;
    index_t req_index;
    offset_t req_offset;
    logic [num_ways-1:0] hit_bits;
    logic req_hit;
    way_t hit_way;
    way_t victim_way;
    select_t new_select;
    logic req_to_hit;
    logic req_to_miss;

    // miss engine
    miss_state_t miss_state;
    logic miss_dirty;
    addr_t miss_addr;
    index_t miss_index;
    way_t miss_way;
    offset_t miss_offset;
    logic [num_words-1:0] ready_bits;
    logic in_miss;
    logic miss_avail;

    // victim buffer, one cycle behind the refill writes
    tag_t victim_tag;
    logic victim_we;
    offset_t victim_offset;
    word_t victim_buf [num_words];
    word_t victim_rdata;

    byte_en_t hit_we;
    byte_en_t fill_we;

    assign req_tag = req_addr[data_width-1 -: tag_bits];
    assign req_index = req_addr[align_bits + offset_bits +: index_bits];
    assign req_offset = req_addr[align_bits +: offset_bits];

    // tag compare across the set
    always_comb begin
        hit_way = '0;
        for (int w = 0; w < num_ways; w++) begin
            hit_bits[w] = valid_bits[req_index][w] && tags[req_index][w] == req_tag;
            if (hit_bits[w]) begin
                hit_way = hit_way | way_t'(w);
            end
        end
    end

    assign req_hit = |hit_bits;

    plru_tree i_plru (
        .select(tree_bits[req_index]),
        .hit_way(hit_way),
        .victim_way(victim_way),
        .new_select(new_select)
    );

    // a hit on the line being refilled must wait for its word
    assign miss_index = miss_addr[align_bits + offset_bits +: index_bits];
    assign in_miss = miss_state != miss_idle && hit_way == miss_way && req_index == miss_index;
    assign addr_ok = req_hit && (!in_miss || ready_bits[req_offset]);
    assign miss_avail = miss_state == miss_idle || (miss_state == miss_writeback && mem.last);
    assign req_to_hit = req_valid && addr_ok;
    assign req_to_miss = req_valid && !req_hit && miss_avail;

    assign hit_we = (req_to_hit && req_is_write) ? req_byte_en : '0;
    assign fill_we = (miss_state == miss_refill && mem.okay) ? '1 : '0;

    // port a serves hits, port b refill and victim readout
    dual_port_bram #(
        .data_width(data_width),
        .addr_width(bram_addr_bits)
    ) i_bram (
        .clk(clk),
        .we_a(hit_we),
        .addr_a({hit_way, req_index, req_offset}),
        .din_a(req_wdata),
        .dout_a(rdata),
        .we_b(fill_we),
        .addr_b({miss_way, miss_index, miss_offset}),
        .din_b(mem.rdata),
        .dout_b(victim_rdata)
    );

    always_ff @(posedge clk) begin
        if (resetn) begin
            data_ok <= 1'b0;
            miss_state <= miss_idle;
            miss_offset <= '0;
            ready_bits <= '0;
            victim_we <= 1'b0;
            for (int s = 0; s < num_sets; s++) begin
                valid_bits[s] <= '0;
                dirty_bits[s] <= '0;
                tree_bits[s] <= '0;
            end
        end else begin
            data_ok <= req_to_hit;
            victim_we <= miss_state == miss_refill && mem.okay;
            if (req_to_hit) begin
                tree_bits[req_index] <= new_select;
                if (req_is_write) begin
                    dirty_bits[req_index][hit_way] <= 1'b1;
                end
            end
            case (miss_state)
                miss_refill: begin
                    if (mem.okay) begin
                        ready_bits[miss_offset] <= 1'b1;
                        miss_offset <= miss_offset + 1'b1;
                        if (mem.last) begin
                            miss_state <= miss_dirty ? miss_writeback : miss_idle;
                        end
                    end
                end
                miss_writeback: begin
                    if (mem.okay) begin
                        miss_offset <= miss_offset + 1'b1;
                        if (mem.last) begin
                            miss_state <= miss_idle;
                        end
                    end
                end
                default: begin
                end
            endcase
            // new miss wins over the end of a writeback
            if (req_to_miss) begin
                miss_state <= miss_refill;
                miss_offset <= req_offset;
                ready_bits <= '0;
                valid_bits[req_index][victim_way] <= 1'b1;
                dirty_bits[req_index][victim_way] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        victim_offset <= miss_offset;
        if (victim_we) begin
            victim_buf[victim_offset] <= victim_rdata;
        end
        if (req_to_miss) begin
            miss_dirty <= dirty_bits[req_index][victim_way];
            victim_tag <= tags[req_index][victim_way];
            miss_addr <= req_addr;
            miss_way <= victim_way;
            tags[req_index][victim_way] <= req_tag;
        end
    end

    // writeback goes to the old line, same start offset
    assign mem.valid = miss_state != miss_idle;
    assign mem.is_write = miss_state == miss_writeback;
    assign mem.addr = (miss_state == miss_writeback)
        ? {victim_tag, miss_addr[data_width-tag_bits-1:0]} : miss_addr;
    assign mem.wdata = victim_buf[miss_offset];

endmodule

// ==== logic/backing_memory.sv ====
`timescale 1ns/1ps

module backing_memory (
    input  logic clk,
    input  logic resetn,
    cbus_if.slave bus
);
    import dcache_pkg::*;

    word_t mem [2 ** mem_words_bits];

    // set after the idle cycle that opens each burst
    logic started;
    offset_t beat;
    offset_t word_sel;
    logic [mem_words_bits-1:0] word_addr;

    // critical word first, wrapping inside the line
    assign word_sel = bus.addr[align_bits +: offset_bits] + beat;
    assign word_addr = {bus.addr[align_bits + offset_bits +: mem_words_bits - offset_bits],
                        word_sel};

    assign bus.okay = bus.valid && started;
    assign bus.last = bus.okay && beat == offset_t'(num_words - 1);
    assign bus.rdata = mem[word_addr];

    always_ff @(posedge clk) begin
        if (resetn) begin
            started <= 1'b0;
            beat <= '0;
            for (int i = 0; i < 2 ** mem_words_bits; i++) begin
                mem[i] <= '0;
            end
        end else begin
            if (bus.okay) begin
                beat <= beat + 1'b1;
                // drop back so the next burst sees its idle cycle
                if (bus.last) begin
                    started <= 1'b0;
                end
                if (bus.is_write) begin
                    mem[word_addr] <= bus.wdata;
                end
            end else if (bus.valid) begin
                started <= 1'b1;
            end
        end
    end

endmodule

// ==== logic/dcache_top.sv ====
`timescale 1ns/1ps

module dcache_top (
    input  logic clk,
    input  logic resetn,

    input  logic req_valid,
    input  dcache_pkg::addr_t req_addr,
    input  logic req_is_write,
    input  dcache_pkg::byte_en_t req_byte_en,
    input  dcache_pkg::word_t req_wdata,
    output logic addr_ok,
    output logic data_ok,
    output dcache_pkg::word_t rdata
);

    // line bursts between cache and memory
    cbus_if i_cbus ();

    dcache i_dcache (
        .clk(clk),
        .resetn(resetn),
        .req_valid(req_valid),
        .req_addr(req_addr),
        .req_is_write(req_is_write),
        .req_byte_en(req_byte_en),
        .req_wdata(req_wdata),
        .addr_ok(addr_ok),
        .data_ok(data_ok),
        .rdata(rdata),
        .mem(i_cbus.master)
    );

    backing_memory i_memory (
        .clk(clk),
        .resetn(resetn),
        .bus(i_cbus.slave)
    );

endmodule

// ==== tests/tb_dcache_top.sv ====
`timescale 1ns/1ps

module tb_dcache_top;
    import dcache_pkg::*;

    localparam int num_ops = 230;
    localparam int watchdog_cycles = num_ops * 20 + 200;
    localparam int req_timeout = 100;

    logic clk;
    logic resetn;
    logic req_valid;
    addr_t req_addr;
    logic req_is_write;
    byte_en_t req_byte_en;
    word_t req_wdata;
    logic addr_ok;
    logic data_ok;
    word_t rdata;

    // byte image of the low 1 KiB that the backing memory covers
    logic [7:0] ref_mem [1024];
    int errors;
    int test_errors;
    int pass_count;
    int fail_count;
    logic accept_q;
    logic read_q;
    word_t expect_q;
    integer seed;

    dcache_top i_dut (
        .clk(clk),
        .resetn(resetn),
        .req_valid(req_valid),
        .req_addr(req_addr),
        .req_is_write(req_is_write),
        .req_byte_en(req_byte_en),
        .req_wdata(req_wdata),
        .addr_ok(addr_ok),
        .data_ok(data_ok),
        .rdata(rdata)
    );

    always #5 clk = ~clk;

    function automatic word_t ref_word(input addr_t addr);
        logic [9:0] base;
        base = {addr[9:2], 2'b00};
        return {ref_mem[base + 3], ref_mem[base + 2], ref_mem[base + 1], ref_mem[base]};
    endfunction

    task automatic ref_store(input addr_t addr, input byte_en_t be, input word_t data);
        logic [9:0] base;
        base = {addr[9:2], 2'b00};
        for (int i = 0; i < 4; i++) begin
            if (be[i]) begin
                ref_mem[base + i] = data[i*8 +: 8];
            end
        end
    endtask

    // response timing and read data checked one cycle after each acceptance
    always @(posedge clk) begin
        if (resetn) begin
            accept_q = 1'b0;
            read_q = 1'b0;
        end else begin
            assert (data_ok === accept_q) else begin
                $display("[FAIL] data_ok expected %h got %h", accept_q, data_ok);
                errors++;
            end
            if (accept_q && read_q) begin
                assert (rdata === expect_q) else begin
                    $display("[FAIL] rdata expected %h got %h", expect_q, rdata);
                    errors++;
                end
            end
            accept_q = req_valid && addr_ok === 1'b1;
            read_q = accept_q && !req_is_write;
            if (accept_q && req_is_write) begin
                ref_store(req_addr, req_byte_en, req_wdata);
            end else if (accept_q) begin
                expect_q = ref_word(req_addr);
            end
        end
    end

    task automatic check_idle_outputs();
        assert (addr_ok === 1'b0) else begin
            $display("[FAIL] addr_ok expected %h got %h", 1'b0, addr_ok);
            errors++;
        end
        assert (data_ok === 1'b0) else begin
            $display("[FAIL] data_ok expected %h got %h", 1'b0, data_ok);
            errors++;
        end
    endtask

    // drive one request until addr_ok and let its data_ok cycle pass
    task automatic access(input logic is_write, input addr_t addr, input byte_en_t be,
                          input word_t wdata, output word_t rd, output int waited);
        logic accepted;
        @(negedge clk);
        req_valid = 1'b1;
        req_is_write = is_write;
        req_addr = addr;
        req_byte_en = be;
        req_wdata = wdata;
        accepted = 1'b0;
        waited = 0;
        while (!accepted && waited < req_timeout) begin
            @(posedge clk);
            if (addr_ok === 1'b1) begin
                accepted = 1'b1;
            end else begin
                waited++;
            end
        end
        // rdata holds the accepted read during the data_ok cycle
        @(negedge clk);
        req_valid = 1'b0;
        rd = rdata;
        if (!accepted) begin
            $display("request to address %h was never accepted", addr);
            errors++;
        end
        @(negedge clk);
    endtask

    task automatic check_word(input addr_t addr, input word_t rd, input word_t expected);
        assert (rd === expected) else begin
            $display("[FAIL] rdata at %h expected %h got %h", addr, expected, rd);
            errors++;
        end
    endtask

    task automatic start_test();
        test_errors = errors;
    endtask

    task automatic finish_test(input string name);
        if (errors == test_errors) begin
            pass_count++;
            $display("test %s: passed", name);
        end else begin
            fail_count++;
            $display("test %s: failed with %0d errors", name, errors - test_errors);
        end
    endtask

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("watchdog: the run did not finish within %0d cycles", watchdog_cycles);
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin
        word_t rd;
        int waited;
        logic [31:0] r;
        addr_t a;
        byte_en_t be;
        clk = 1'b0;
        resetn = 1'b1;
        req_valid = 1'b0;
        req_addr = '0;
        req_is_write = 1'b0;
        req_byte_en = '0;
        req_wdata = '0;
        seed = 19;
        errors = 0;
        pass_count = 0;
        fail_count = 0;
        accept_q = 1'b0;
        read_q = 1'b0;
        expect_q = '0;
        for (int i = 0; i < 1024; i++) begin
            ref_mem[i] = 8'h00;
        end

        start_test();
        repeat (2) begin
            @(negedge clk);
            check_idle_outputs();
        end
        resetn = 1'b0;
        @(negedge clk);
        check_idle_outputs();
        access(1'b0, 32'h0000_0234, 4'h0, '0, rd, waited);
        check_word(32'h0000_0234, rd, 32'h0);
        finish_test("reset and cold read");

        start_test();
        for (int i = 0; i < 3; i++) begin
            access(1'b0, 32'h0000_0234, 4'h0, '0, rd, waited);
            assert (waited == 0) else begin
                $display("read of a filled word was not accepted in its first cycle");
                errors++;
            end
        end
        finish_test("hit timing");

        start_test();
        access(1'b1, 32'h0000_0088, 4'hf, 32'h1122_3344, rd, waited);
        access(1'b1, 32'h0000_0088, 4'h1, 32'h0000_00aa, rd, waited);
        access(1'b1, 32'h0000_0088, 4'h6, 32'h00bb_cc00, rd, waited);
        access(1'b1, 32'h0000_0088, 4'h8, 32'hdd00_0000, rd, waited);
        access(1'b0, 32'h0000_0088, 4'h0, '0, rd, waited);
        check_word(32'h0000_0088, rd, 32'hddbb_ccaa);
        // partial write allocates over a line of zeros
        access(1'b1, 32'h0000_00c4, 4'hc, 32'h5566_7788, rd, waited);
        access(1'b0, 32'h0000_00c4, 4'h0, '0, rd, waited);
        check_word(32'h0000_00c4, rd, 32'h5566_0000);
        finish_test("byte masks");

        start_test();
        // five tags in set 1 overflow its four ways
        for (int t = 0; t < 5; t++) begin
            a = {22'b0, 4'(t), 2'd1, 2'(t), 2'b00};
            access(1'b1, a, 4'hf, 32'hc0de_0000 + t * 32'h1111, rd, waited);
        end
        for (int t = 0; t < 5; t++) begin
            a = {22'b0, 4'(t), 2'd1, 2'(t), 2'b00};
            access(1'b0, a, 4'h0, '0, rd, waited);
            check_word(a, rd, 32'hc0de_0000 + t * 32'h1111);
        end
        finish_test("dirty eviction");

        start_test();
        // 16 lines as eight tags in each of sets 1 and 3
        for (int i = 0; i < 200; i++) begin
            r = $random(seed);
            a = {22'b0, 1'b0, r[3:1], r[0] ? 2'd3 : 2'd1, r[5:4], 2'b00};
            be = r[11:8];
            if (be == 4'h0) begin
                be = 4'hf;
            end
            access(r[6], a, be, $random(seed), rd, waited);
        end
        finish_test("random traffic");

        $display("tests passed: %0d, failed: %0d, errors: %0d", pass_count, fail_count, errors);
        if (fail_count == 0 && errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== dcache_sys.f ====
logic/dcache_pkg.sv
logic/cbus_if.sv
logic/dual_port_bram.sv
logic/plru_tree.sv
logic/dcache.sv
logic/backing_memory.sv
logic/dcache_top.sv
tests/tb_dcache_top.sv

// ==== Bender.yml ====
package:
  name: dcache_sys

sources:
  - logic/dcache_pkg.sv
  - logic/cbus_if.sv
  - logic/dual_port_bram.sv
  - logic/plru_tree.sv
  - logic/dcache.sv
  - logic/backing_memory.sv
  - logic/dcache_top.sv
  - target: test
    files:
      - tests/tb_dcache_top.sv
